//--- common/wb_cache_params.svh
/*
 * Write-back cache parameters
 * Address fields, line length and RAM geometry for the two-way cache
 */
`ifndef WB_CACHE_PARAMS_SVH
`define WB_CACHE_PARAMS_SVH

// ----------------------------------------
// Wishbone side
// ----------------------------------------
`define WB_ADR_W    26
`define DAT_W       32
`define SEL_W       4

// Byte address split into tag, set and word in line
`define WORD_W      2
`define SET_W       7
`define TAG_W       15
`define WORD_LSB    2
`define SET_LSB     (`WORD_LSB + `WORD_W)
`define TAG_LSB     (`SET_LSB + `SET_W)

`define LINE_WORDS  4

// ----------------------------------------
// Memory side and RAM sizes
// ----------------------------------------
`define FML_ADR_W   (`TAG_W + `SET_W)

`define TAG_RAM_AW  (`SET_W)
`define TAG_RAM_DW  (2 * `TAG_W + 3)
`define WAY_RAM_AW  (`SET_W + `WORD_W)
`define WAY_RAM_DW  (`DAT_W + `SEL_W)

`endif

//--- common/wb_cache_pkg.sv
/*
 * Shared types of the write-back cache
 * Wishbone request, RAM words, FML link and RAM port bundles
 */
`include "wb_cache_params.svh"

package wb_cache_pkg;

	// Whole Wishbone classic request from the master
	typedef struct packed {
		logic                 cyc;
		logic                 stb;
		logic                 we;
		logic [`WB_ADR_W-1:0] adr;
		logic [`DAT_W-1:0]    dat;
		logic [`SEL_W-1:0]    sel;
	} wb_req_t;

	// One tag RAM word, lru set means way 0 is the next victim
	typedef struct packed {
		logic [`TAG_W-1:0] tag0;
		logic [`TAG_W-1:0] tag1;
		logic              dirty0;
		logic              dirty1;
		logic              lru;
	} tag_line_t;

	// One way RAM word with a valid bit per byte
	typedef struct packed {
		logic [`DAT_W-1:0] dat;
		logic [`SEL_W-1:0] valid;
	} way_word_t;

	// ----------------------------------------
	// FML link
	// ----------------------------------------
	typedef struct packed {
		logic                  rd;
		logic                  wr;
		logic [`FML_ADR_W-1:0] adr;
		logic [`DAT_W-1:0]     wdat;
		logic [`SEL_W-1:0]     wbe;
		logic                  wnext;
		logic                  rnext;
	} fml_req_t;

	typedef struct packed {
		logic              done;
		logic              rempty;
		logic [`DAT_W-1:0] rdat;
	} fml_rsp_t;

	// One engine's access to the tag and way RAMs
	typedef struct packed {
		logic [`WAY_RAM_AW-1:0] adr;
		tag_line_t              tag_store;
		way_word_t              way_store;
		logic                   tag_we;
		logic                   way0_we;
		logic                   way1_we;
	} ram_port_t;

endpackage

//--- rtl/dpram.sv
/*
 * True dual-port synchronous RAM
 * Read-first on both ports, contents start at zero
 */
`timescale 1ns/10ps

module dpram #(
	parameter int adr_width = 9,
	parameter int dat_width = 36
) (
	input  logic                 clk,
	input  logic [adr_width-1:0] adr0_i,
	input  logic [dat_width-1:0] din0_i,
	input  logic                 we0_i,
	output logic [dat_width-1:0] dout0_o,
	input  logic [adr_width-1:0] adr1_i,
	input  logic [dat_width-1:0] din1_i,
	input  logic                 we1_i,
	output logic [dat_width-1:0] dout1_o
);

	logic [dat_width-1:0] mem [0:(1 << adr_width) - 1];

	initial begin
		for (int i = 0; i < (1 << adr_width); i++) begin
			mem[i] = '0;
		end
	end

	// Port 0
	always @(posedge clk) begin
		dout0_o <= mem[adr0_i];
		if (we0_i) begin
			mem[adr0_i] <= din0_i;
		end
	end

	// Port 1
	always @(posedge clk) begin
		dout1_o <= mem[adr1_i];
		if (we1_i) begin
			mem[adr1_i] <= din1_i;
		end
	end

endmodule

//--- cache/cache_arrays.sv
/*
 * Cache arrays
 * Tag RAM and both way RAMs, hit engine on port A, line mover on port B
 */
`timescale 1ns/10ps
`include "wb_cache_params.svh"

module cache_arrays (
	input  logic                    clk,
	input  wb_cache_pkg::ram_port_t port_a_i,
	input  wb_cache_pkg::ram_port_t port_b_i,
	output wb_cache_pkg::tag_line_t tag_a_o,
	output wb_cache_pkg::tag_line_t tag_b_o,
	output wb_cache_pkg::way_word_t way0_a_o,
	output wb_cache_pkg::way_word_t way1_a_o,
	output wb_cache_pkg::way_word_t way0_b_o,
	output wb_cache_pkg::way_word_t way1_b_o
);

	// Tag RAM is indexed by set only
	dpram #(
		.adr_width(`TAG_RAM_AW),
		.dat_width(`TAG_RAM_DW)
	) tag_ram (
		.clk     (clk),
		.adr0_i  (port_a_i.adr[`WAY_RAM_AW-1:`WORD_W]),
		.din0_i  (port_a_i.tag_store),
		.we0_i   (port_a_i.tag_we),
		.dout0_o (tag_a_o),
		.adr1_i  (port_b_i.adr[`WAY_RAM_AW-1:`WORD_W]),
		.din1_i  (port_b_i.tag_store),
		.we1_i   (port_b_i.tag_we),
		.dout1_o (tag_b_o)
	);

	dpram #(
		.adr_width(`WAY_RAM_AW),
		.dat_width(`WAY_RAM_DW)
	) way0_ram (
		.clk     (clk),
		.adr0_i  (port_a_i.adr),
		.din0_i  (port_a_i.way_store),
		.we0_i   (port_a_i.way0_we),
		.dout0_o (way0_a_o),
		.adr1_i  (port_b_i.adr),
		.din1_i  (port_b_i.way_store),
		.we1_i   (port_b_i.way0_we),
		.dout1_o (way0_b_o)
	);

	dpram #(
		.adr_width(`WAY_RAM_AW),
		.dat_width(`WAY_RAM_DW)
	) way1_ram (
		.clk     (clk),
		.adr0_i  (port_a_i.adr),
		.din0_i  (port_a_i.way_store),
		.we0_i   (port_a_i.way1_we),
		.dout0_o (way1_a_o),
		.adr1_i  (port_b_i.adr),
		.din1_i  (port_b_i.way_store),
		.we1_i   (port_b_i.way1_we),
		.dout1_o (way1_b_o)
	);

endmodule

//--- cache/hit_engine.sv
/*
 * Hit engine
 * Wishbone FSM with tag compare, byte merge, LRU and dirty update,
 * hands misses to the line mover
 */
`timescale 1ns/10ps
`include "wb_cache_params.svh"

module hit_engine (
	input  logic                    clk,
	input  logic                    reset,
	input  wb_cache_pkg::wb_req_t   wb_req_i,
	output logic [`DAT_W-1:0]       wb_dat_o,
	output logic                    wb_ack_o,
	input  wb_cache_pkg::tag_line_t tag_i,
	input  wb_cache_pkg::way_word_t way0_i,
	input  wb_cache_pkg::way_word_t way1_i,
	output wb_cache_pkg::ram_port_t port_a_o,
	input  logic                    busy_i,
	output logic                    fill_o,
	output logic                    spill_o,
	output logic                    ls_way_o,
	output logic [`TAG_W-1:0]       ls_tag_o,
	output logic [`SET_W-1:0]       ls_set_o
);

	typedef enum logic [2:0] {
		s_idle,
		s_read,
		s_rspill,
		s_rfill,
		s_write,
		s_wspill
	} state_t;

	state_t state;
	logic   spilled;

	logic                    wb_rd;
	logic                    wb_wr;
	logic [`WORD_W-1:0]      adr_word;
	logic [`SET_W-1:0]       adr_set;
	logic [`TAG_W-1:0]       adr_tag;
	logic                    match0;
	logic                    match1;
	logic                    match;
	logic                    sel_valid0;
	logic                    sel_valid1;
	logic                    hit;
	logic                    lru_way;
	logic                    use_way;
	logic                    use_dirty;
	logic [`TAG_W-1:0]       use_tag;
	wb_cache_pkg::way_word_t use_line;
	logic                    write_ok;
	logic                    rd_ack;
	logic                    wr_ack;
	logic                    start_req;
	logic                    go_spill;
	logic                    go_fill;

	assign wb_rd = wb_req_i.cyc & wb_req_i.stb & ~wb_req_i.we;
	assign wb_wr = wb_req_i.cyc & wb_req_i.stb & wb_req_i.we;

	assign adr_word = wb_req_i.adr[`SET_LSB-1:`WORD_LSB];
	assign adr_set  = wb_req_i.adr[`TAG_LSB-1:`SET_LSB];
	assign adr_tag  = wb_req_i.adr[`WB_ADR_W-1:`TAG_LSB];

	// ----------------------------------------
	// Lookup
	// ----------------------------------------
	assign match0     = (tag_i.tag0 == adr_tag);
	assign match1     = (tag_i.tag1 == adr_tag);
	assign match      = match0 | match1;
	assign sel_valid0 = ((~way0_i.valid & wb_req_i.sel) == '0);
	assign sel_valid1 = ((~way1_i.valid & wb_req_i.sel) == '0);
	assign hit        = match & (match0 ? sel_valid0 : sel_valid1);

	// Matching way wins, way 0 first, otherwise the LRU victim
	assign lru_way   = ~tag_i.lru;
	assign use_way   = match ? ~match0 : lru_way;
	assign use_line  = use_way ? way1_i : way0_i;
	assign use_dirty = use_way ? tag_i.dirty1 : tag_i.dirty0;
	assign use_tag   = use_way ? tag_i.tag1 : tag_i.tag0;

	// A fresh line is only taken once its stale bytes were spilled
	assign write_ok = match | (spilled & ~use_dirty);

	assign rd_ack   = (state == s_read) & hit;
	assign wr_ack   = (state == s_write) & write_ok;
	assign wb_ack_o = rd_ack | wr_ack;
	assign wb_dat_o = use_line.dat;

	// Miss handling requests
	assign start_req = ~busy_i & (((state == s_read) & ~hit) |
		((state == s_write) & ~write_ok));
	assign go_spill  = start_req & ((state == s_write) | use_dirty);
	assign go_fill   = (start_req & ~go_spill) | ((state == s_rspill) & ~busy_i);

	// ----------------------------------------
	// RAM port A
	// ----------------------------------------
	always_comb begin
		port_a_o.adr = {adr_set, adr_word};

		// Byte merge by sel
		for (int b = 0; b < `SEL_W; b++) begin
			if (wb_req_i.sel[b]) begin
				port_a_o.way_store.dat[8*b +: 8] = wb_req_i.dat[8*b +: 8];
				port_a_o.way_store.valid[b]      = 1'b1;
			end else begin
				port_a_o.way_store.dat[8*b +: 8] = use_line.dat[8*b +: 8];
				port_a_o.way_store.valid[b]      = use_line.valid[b];
			end
		end

		port_a_o.tag_store     = tag_i;
		port_a_o.tag_store.lru = use_way;
		if (wr_ack) begin
			if (use_way) begin
				port_a_o.tag_store.tag1   = adr_tag;
				port_a_o.tag_store.dirty1 = 1'b1;
			end else begin
				port_a_o.tag_store.tag0   = adr_tag;
				port_a_o.tag_store.dirty0 = 1'b1;
			end
		end

		port_a_o.tag_we  = wb_ack_o;
		port_a_o.way0_we = wr_ack & ~use_way;
		port_a_o.way1_we = wr_ack & use_way;
	end

	// ----------------------------------------
	// Wishbone FSM
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= s_idle;
			fill_o  <= 1'b0;
			spill_o <= 1'b0;
			spilled <= 1'b0;
		end else begin
			fill_o  <= go_fill;
			spill_o <= go_spill;

			case (state)
			s_idle: begin
				if (wb_rd) begin
					state <= s_read;
				end else if (wb_wr) begin
					state <= s_write;
				end
			end
			s_read: begin
				if (hit) begin
					state <= s_idle;
				end else if (go_spill) begin
					state <= s_rspill;
				end else if (go_fill) begin
					state <= s_rfill;
				end
			end
			s_rspill: begin
				if (~busy_i) begin
					state <= s_rfill;
				end
			end
			s_rfill: begin
				// Retry the lookup once the line is in
				if (~busy_i) begin
					state <= s_idle;
				end
			end
			s_write: begin
				if (write_ok) begin
					state   <= s_idle;
					spilled <= 1'b0;
				end else if (go_spill) begin
					state <= s_wspill;
				end
			end
			s_wspill: begin
				if (~busy_i) begin
					state   <= s_idle;
					spilled <= 1'b1;
				end
			end
			default: begin
				state <= s_idle;
			end
			endcase
		end
	end

	// Line mover job, held for the whole transfer
	always_ff @(posedge clk) begin
		if (start_req) begin
			ls_way_o <= use_way;
			ls_set_o <= adr_set;
		end
		if (go_spill) begin
			ls_tag_o <= use_tag;
		end else if (go_fill) begin
			ls_tag_o <= adr_tag;
		end
	end

endmodule

//--- cache/line_mover.sv
/*
 * Line mover
 * Spills a victim line to memory and fills a line from memory over FML
 */
`timescale 1ns/10ps
`include "wb_cache_params.svh"

module line_mover (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    fill_i,
	input  logic                    spill_i,
	input  logic                    way_i,
	input  logic [`TAG_W-1:0]       tag_i,
	input  logic [`SET_W-1:0]       set_i,
	output logic                    busy_o,
	input  wb_cache_pkg::tag_line_t tag_i_b,
	input  wb_cache_pkg::way_word_t way0_i,
	input  wb_cache_pkg::way_word_t way1_i,
	output wb_cache_pkg::ram_port_t port_b_o,
	output wb_cache_pkg::fml_req_t  fml_o,
	input  wb_cache_pkg::fml_rsp_t  fml_i
);

	typedef enum logic [1:0] {
		m_idle,
		m_spill,
		m_wait,
		m_fill
	} state_t;

	state_t                  state;
	logic [`WORD_W-1:0]      word;
	logic                    rd_q;
	logic                    wr_q;
	logic                    wnext_q;
	logic                    last_word;
	logic                    spill_rd;
	logic                    fill_wr;
	wb_cache_pkg::way_word_t victim;

	assign last_word = (word == (`LINE_WORDS - 1));
	assign busy_o    = (state != m_idle) | fill_i | spill_i;

	// Victim word read, valid bits dropped in the same cycle
	assign spill_rd = ((state == m_idle) & spill_i) | (state == m_spill);
	assign fill_wr  = (state == m_fill) & ~fml_i.rempty;
	assign victim   = way_i ? way1_i : way0_i;

	// ----------------------------------------
	// FML side
	// ----------------------------------------
	always_comb begin
		fml_o.rd    = rd_q;
		fml_o.wr    = wr_q;
		fml_o.adr   = {tag_i, set_i};
		fml_o.wdat  = victim.dat;
		fml_o.wbe   = victim.valid;
		// One cycle behind the read, in step with RAM data
		fml_o.wnext = wnext_q;
		fml_o.rnext = fill_wr;
	end

	// ----------------------------------------
	// RAM port B
	// ----------------------------------------
	always_comb begin
		port_b_o.adr             = {set_i, word};
		port_b_o.way_store.dat   = fml_i.rdat;
		port_b_o.way_store.valid = {`SEL_W{state == m_fill}};
		port_b_o.way0_we         = (spill_rd | fill_wr) & ~way_i;
		port_b_o.way1_we         = (spill_rd | fill_wr) & way_i;

		port_b_o.tag_store = tag_i_b;
		if (way_i) begin
			port_b_o.tag_store.dirty1 = 1'b0;
			if (state == m_fill) begin
				port_b_o.tag_store.tag1 = tag_i;
			end
		end else begin
			port_b_o.tag_store.dirty0 = 1'b0;
			if (state == m_fill) begin
				port_b_o.tag_store.tag0 = tag_i;
			end
		end

		// New tag with the last fill word, clean once memory took the spill
		port_b_o.tag_we = (fill_wr & last_word) |
			((state == m_wait) & wr_q & fml_i.done);
	end

	// ----------------------------------------
	// Mover FSM
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= m_idle;
			word    <= '0;
			rd_q    <= 1'b0;
			wr_q    <= 1'b0;
			wnext_q <= 1'b0;
		end else begin
			wnext_q <= spill_rd;

			case (state)
			m_idle: begin
				word <= '0;
				if (spill_i) begin
					state <= m_spill;
					word  <= 1;
				end else if (fill_i) begin
					state <= m_fill;
					rd_q  <= 1'b1;
				end
			end
			m_spill: begin
				word <= word + 1'b1;
				if (last_word) begin
					state <= m_wait;
				end
			end
			m_wait: begin
				// wr goes up after the last wnext
				if (~rd_q & ~wr_q) begin
					wr_q <= 1'b1;
				end
				if (fml_i.done & (rd_q | wr_q)) begin
					state <= m_idle;
					rd_q  <= 1'b0;
					wr_q  <= 1'b0;
				end
			end
			m_fill: begin
				if (fml_i.done) begin
					rd_q <= 1'b0;
				end
				if (~fml_i.rempty) begin
					word <= word + 1'b1;
					if (last_word) begin
						state <= (rd_q & ~fml_i.done) ? m_wait : m_idle;
					end
				end
			end
			default: begin
				state <= m_idle;
			end
			endcase
		end
	end

endmodule

//--- cache/wb_cache.sv
/*
 * Two-way set-associative write-back cache
 * Wishbone classic slave in front, FML line link to memory behind
 */
`timescale 1ns/10ps
`include "wb_cache_params.svh"

module wb_cache (
	input  logic                   clk,
	input  logic                   reset,
	input  wb_cache_pkg::wb_req_t  wb_req_i,
	output logic [`DAT_W-1:0]      wb_dat_o,
	output logic                   wb_ack_o,
	output wb_cache_pkg::fml_req_t fml_o,
	input  wb_cache_pkg::fml_rsp_t fml_i
);

	wb_cache_pkg::ram_port_t port_a;
	wb_cache_pkg::ram_port_t port_b;
	wb_cache_pkg::tag_line_t tag_a;
	wb_cache_pkg::tag_line_t tag_b;
	wb_cache_pkg::way_word_t way0_a;
	wb_cache_pkg::way_word_t way1_a;
	wb_cache_pkg::way_word_t way0_b;
	wb_cache_pkg::way_word_t way1_b;

	// Job handed from hit engine to line mover
	logic              ls_busy;
	logic              ls_fill;
	logic              ls_spill;
	logic              ls_way;
	logic [`TAG_W-1:0] ls_tag;
	logic [`SET_W-1:0] ls_set;

	hit_engine hit_engine (
		.clk      (clk),
		.reset    (reset),
		.wb_req_i (wb_req_i),
		.wb_dat_o (wb_dat_o),
		.wb_ack_o (wb_ack_o),
		.tag_i    (tag_a),
		.way0_i   (way0_a),
		.way1_i   (way1_a),
		.port_a_o (port_a),
		.busy_i   (ls_busy),
		.fill_o   (ls_fill),
		.spill_o  (ls_spill),
		.ls_way_o (ls_way),
		.ls_tag_o (ls_tag),
		.ls_set_o (ls_set)
	);

	line_mover line_mover (
		.clk      (clk),
		.reset    (reset),
		.fill_i   (ls_fill),
		.spill_i  (ls_spill),
		.way_i    (ls_way),
		.tag_i    (ls_tag),
		.set_i    (ls_set),
		.busy_o   (ls_busy),
		.tag_i_b  (tag_b),
		.way0_i   (way0_b),
		.way1_i   (way1_b),
		.port_b_o (port_b),
		.fml_o    (fml_o),
		.fml_i    (fml_i)
	);

	cache_arrays cache_arrays (
		.clk      (clk),
		.port_a_i (port_a),
		.port_b_i (port_b),
		.tag_a_o  (tag_a),
		.tag_b_o  (tag_b),
		.way0_a_o (way0_a),
		.way1_a_o (way1_a),
		.way0_b_o (way0_b),
		.way1_b_o (way1_b)
	);

endmodule

//--- sim/wb_cache_props.sv
/*
 * Protocol properties of the cache ports
 * Wishbone ack and FML link rules, bound into the cache top level
 */
`timescale 1ns/10ps

module wb_cache_props (
	input logic                   clk,
	input logic                   reset,
	input wb_cache_pkg::wb_req_t  wb_req_i,
	input logic                   wb_ack_o,
	input wb_cache_pkg::fml_req_t fml_o,
	input wb_cache_pkg::fml_rsp_t fml_i
);

	int fail_count = 0;

	// Ack only answers a live request
	ack_with_request: assert property (@(posedge clk) disable iff (reset)
		wb_ack_o |-> (wb_req_i.cyc && wb_req_i.stb))
	else begin
		$error("wb_ack_o high without cyc and stb");
		fail_count++;
	end

	// One direction at a time on the memory link
	rd_wr_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(fml_o.rd && fml_o.wr))
	else begin
		$error("fml rd and wr high together");
		fail_count++;
	end

	// Request levels stay up until memory answers with done
	rd_held_to_done: assert property (@(posedge clk) disable iff (reset)
		(fml_o.rd && !fml_i.done) |=> fml_o.rd)
	else begin
		$error("fml rd dropped before done");
		fail_count++;
	end

	wr_held_to_done: assert property (@(posedge clk) disable iff (reset)
		(fml_o.wr && !fml_i.done) |=> fml_o.wr)
	else begin
		$error("fml wr dropped before done");
		fail_count++;
	end

endmodule

bind wb_cache wb_cache_props props (
	.clk      (clk),
	.reset    (reset),
	.wb_req_i (wb_req_i),
	.wb_ack_o (wb_ack_o),
	.fml_o    (fml_o),
	.fml_i    (fml_i)
);

//--- sim/wb_cache_tb.sv
/*
 * Testbench for the two-way write-back cache
 * Wishbone master, FML memory model, reference byte image and read checks
 */
`timescale 1ns/10ps
`include "wb_cache_params.svh"

module wb_cache_tb;

	localparam int n_directed = 21;
	localparam int n_random   = 400;
	localparam int max_cycles = (n_directed + n_random) * 60 + 10;
	localparam int mem_words  = 4096;

	logic                   clk;
	logic                   reset;
	wb_cache_pkg::wb_req_t  wb_req;
	logic [`DAT_W-1:0]      wb_dat;
	logic                   wb_ack;
	wb_cache_pkg::fml_req_t fml_req;
	wb_cache_pkg::fml_rsp_t fml_rsp;

	// Backing memory and the expected byte image, both word indexed
	logic [`DAT_W-1:0] mem_model [0:mem_words-1];
	logic [`DAT_W-1:0] ref_image [0:mem_words-1];
	logic [`DAT_W-1:0] exp_q [$];

	int rd_cnt;
	int wr_cnt;
	int latency;
	int cycle_cnt;
	int seed_dummy;

	wb_cache dut (
		.clk      (clk),
		.reset    (reset),
		.wb_req_i (wb_req),
		.wb_dat_o (wb_dat),
		.wb_ack_o (wb_ack),
		.fml_o    (fml_req),
		.fml_i    (fml_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ----------------------------------------
	// Helpers
	// ----------------------------------------
	function automatic logic [`DAT_W-1:0] init_word(input int unsigned idx);
		logic [31:0] a;
		a = idx;
		return (a * 32'h9e37_79b1) ^ {a[15:0], ~a[15:0]};
	endfunction

	function automatic logic [`WB_ADR_W-1:0] make_adr(input logic [`TAG_W-1:0] tag,
		input logic [`SET_W-1:0] set_idx, input logic [`WORD_W-1:0] word);
		return {tag, set_idx, word, 2'b00};
	endfunction

	function automatic logic [`SET_W-1:0] pick_set(input int k);
		case (k)
		0:       return 7'd3;
		1:       return 7'd64;
		default: return 7'd127;
		endcase
	endfunction

	function automatic logic [`DAT_W-1:0] byte_mask(input logic [`SEL_W-1:0] sel);
		return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
	endfunction

	// Expected word after the access, writes merge by sel
	function automatic logic [`DAT_W-1:0] ref_model(input logic we,
		input logic [`WB_ADR_W-1:0] adr, input logic [`DAT_W-1:0] dat,
		input logic [`SEL_W-1:0] sel);
		int idx;
		idx = adr[13:2];
		if (we) begin
			for (int b = 0; b < `SEL_W; b++) begin
				if (sel[b]) begin
					ref_image[idx][8*b +: 8] = dat[8*b +: 8];
				end
			end
		end
		return ref_image[idx];
	endfunction

	task automatic report_error(input string what);
		$display("%s", what);
		$display("RESULT: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			report_error($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
		end
	endtask

	// One Wishbone classic cycle, latency counts edges up to the ack
	task automatic run_transaction(input logic we, input logic [`WB_ADR_W-1:0] adr,
		input logic [`DAT_W-1:0] dat, input logic [`SEL_W-1:0] sel);
		logic [`DAT_W-1:0] expected;
		expected = ref_model(we, adr, dat, sel);
		if (!we) begin
			exp_q.push_back(expected);
		end
		latency = 0;
		wb_req.cyc <= 1'b1;
		wb_req.stb <= 1'b1;
		wb_req.we  <= we;
		wb_req.adr <= adr;
		wb_req.dat <= dat;
		wb_req.sel <= sel;
		do begin
			@(posedge clk);
			latency++;
		end while (!wb_ack);
		wb_req.cyc <= 1'b0;
		wb_req.stb <= 1'b0;
		@(posedge clk);
	endtask

	// ----------------------------------------
	// FML memory model
	// ----------------------------------------
	always @(posedge clk) begin : fml_memory
		int line_adr;
		line_adr = fml_req.adr;
		if (reset) begin
			fml_rsp.done   <= 1'b0;
			fml_rsp.rempty <= 1'b1;
			fml_rsp.rdat   <= '0;
			rd_cnt = 0;
			wr_cnt = 0;
		end else if ((fml_req.rd || fml_req.wnext) && line_adr >= mem_words / 4) begin
			report_error("Memory access outside the modeled address range");
		end else begin
			fml_rsp.done <= 1'b0;
			// Spill words arrive before wr, bytes applied by wbe
			if (fml_req.wnext) begin
				for (int b = 0; b < `SEL_W; b++) begin
					if (fml_req.wbe[b]) begin
						mem_model[line_adr*4 + wr_cnt][8*b +: 8] = fml_req.wdat[8*b +: 8];
					end
				end
				wr_cnt++;
			end
			if (fml_req.wr && !fml_rsp.done) begin
				fml_rsp.done <= 1'b1;
				wr_cnt = 0;
			end
			if (fml_req.rd) begin
				if (fml_req.rnext) begin
					rd_cnt++;
				end
				if (rd_cnt < `LINE_WORDS) begin
					fml_rsp.rempty <= 1'b0;
					fml_rsp.rdat   <= mem_model[line_adr*4 + rd_cnt];
				end else begin
					fml_rsp.rempty <= 1'b1;
					if (!fml_rsp.done) begin
						fml_rsp.done <= 1'b1;
					end
				end
			end else begin
				rd_cnt = 0;
				fml_rsp.rempty <= 1'b1;
			end
		end
	end

	// ----------------------------------------
	// Read data check and watchdogs
	// ----------------------------------------
	always @(posedge clk) begin : check_reads
		logic [`DAT_W-1:0] mask;
		logic [`DAT_W-1:0] expected;
		mask = byte_mask(wb_req.sel);
		if (!reset && wb_ack && wb_req.cyc && wb_req.stb && !wb_req.we) begin
			expected = exp_q.pop_front();
			compare_value("wb_dat_o", expected & mask, wb_dat & mask);
		end
	end

	always @(posedge clk) begin
		if (dut.props.fail_count != 0) begin
			report_error("A protocol assertion on the cache ports failed");
		end
	end

	initial begin : watchdog
		cycle_cnt = 0;
		while (cycle_cnt < max_cycles) begin
			@(posedge clk);
			cycle_cnt++;
		end
		report_error($sformatf("Timeout after %0d cycles, a transaction never completed",
			cycle_cnt));
	end

	// ----------------------------------------
	// Stimulus
	// ----------------------------------------
	initial begin : stimulus
		logic                 we;
		logic [`TAG_W-1:0]    tag_r;
		logic [`SET_W-1:0]    set_r;
		logic [`WORD_W-1:0]   word_r;
		logic [`DAT_W-1:0]    dat_r;
		logic [`SEL_W-1:0]    sel_r;

		seed_dummy = $urandom(26);
		reset      = 1'b1;
		wb_req     = '0;
		fml_rsp    = '{done: 1'b0, rempty: 1'b1, rdat: '0};
		for (int i = 0; i < mem_words; i++) begin
			mem_model[i] = init_word(i);
			ref_image[i] = init_word(i);
		end
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);

		// Fresh line comes in through a fill
		run_transaction(1'b0, make_adr(1, 3, 0), '0, 4'hf);

		// Write then read back, full and partial
		run_transaction(1'b1, make_adr(1, 3, 1), 32'hdead_beef, 4'hf);
		run_transaction(1'b0, make_adr(1, 3, 1), '0, 4'hf);
		run_transaction(1'b1, make_adr(1, 3, 1), 32'h1234_5678, 4'b0101);
		run_transaction(1'b0, make_adr(1, 3, 1), '0, 4'hf);

		// Partial store to an uncached line, full read spills then fills
		run_transaction(1'b1, make_adr(2, 64, 2), 32'hcafe_f00d, 4'b0110);
		run_transaction(1'b0, make_adr(2, 64, 2), '0, 4'hf);

		// Four tags through one set force dirty evictions
		for (int t = 1; t <= 4; t++) begin
			run_transaction(1'b1, make_adr(t, 127, t - 1), 32'h0a0b_0c00 + t, 4'hf);
		end
		for (int r = 0; r < 2; r++) begin
			for (int t = 1; t <= 4; t++) begin
				run_transaction(1'b0, make_adr(t, 127, t - 1), '0, 4'hf);
			end
		end

		// Second read of a cached line is a plain hit
		run_transaction(1'b0, make_adr(3, 3, 3), '0, 4'hf);
		run_transaction(1'b0, make_adr(3, 3, 3), '0, 4'hf);
		compare_value("hit_latency", 2, latency);

		// Random mix over 3 sets and 5 tags
		for (int i = 0; i < n_random; i++) begin
			we     = ($urandom % 2) == 1;
			tag_r  = 1 + ($urandom % 5);
			set_r  = pick_set($urandom % 3);
			word_r = $urandom % 4;
			dat_r  = $urandom;
			sel_r  = 1 + ($urandom % 15);
			if (!we && ($urandom % 4) != 0) begin
				sel_r = 4'hf;
			end
			run_transaction(we, make_adr(tag_r, set_r, word_r), dat_r, sel_r);
		end

		$display("RESULT: PASS");
		$finish;
	end

endmodule

//--- wb_cache.f
+incdir+common
common/wb_cache_pkg.sv
rtl/dpram.sv
cache/cache_arrays.sv
cache/hit_engine.sv
cache/line_mover.sv
cache/wb_cache.sv
sim/wb_cache_props.sv
sim/wb_cache_tb.sv

//--- Bender.yml
package:
  name: wb_cache

sources:
  - include_dirs:
      - common
    files:
      - common/wb_cache_pkg.sv
      - rtl/dpram.sv
      - cache/cache_arrays.sv
      - cache/hit_engine.sv
      - cache/line_mover.sv
      - cache/wb_cache.sv
  - target: test
    include_dirs:
      - common
    files:
      - sim/wb_cache_props.sv
      - sim/wb_cache_tb.sv
